// ==== common/isa_pkg.sv ====
// isa definitions for the rename core
// instruction word formats, opcodes and the two views of one word

package isa_pkg;

    localparam int xlen   = 32;  // instruction word width
    localparam int areg_w = 5;   // architectural register index

    // major opcodes seen by dispatch
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,  // register-register alu
        op_imm   = 7'b0010011,  // register-immediate alu
        op_load  = 7'b0000011,
        op_store = 7'b0100011   // no destination
    } opcode_t;

    // register-register layout
    typedef struct packed {
        logic [6:0]        funct7;
        logic [areg_w-1:0] rs2;
        logic [areg_w-1:0] rs1;
        logic [2:0]        funct3;
        logic [areg_w-1:0] rd;
        opcode_t           opcode;
    } r_fields_t;

    // immediate layout, no second source
    typedef struct packed {
        logic [11:0]       imm12;
        logic [areg_w-1:0] rs1;
        logic [2:0]        funct3;
        logic [areg_w-1:0] rd;
        opcode_t           opcode;
    } i_fields_t;

    // one word, decoded either way
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    localparam logic [xlen-1:0] nop_word = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// ==== common/core_pkg.sv ====
// rename core sizes and the packed records passed between its blocks
// dispatch input, allocation, lookup, rename result, completion, retire

package core_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    localparam int num_areg  = 32;
    localparam int num_preg  = 64;
    localparam int preg_w    = 6;                    // physical tag width
    localparam int fl_depth  = num_preg - num_areg;  // free list slots
    localparam int fl_w      = 5;
    localparam int rob_depth = 16;
    localparam int rob_w     = 4;

    typedef logic [isa_pkg::areg_w-1:0] areg_t;
    typedef logic [preg_w-1:0]          preg_t;
    typedef logic [rob_w-1:0]           rob_idx_t;

    //////////////////////////////////////////////////
    // records
    //////////////////////////////////////////////////
    typedef struct packed {
        logic           valid;
        isa_pkg::inst_u inst;
    } disp_in_t;

    // dispatch request to map table, free list and rob
    typedef struct packed {
        logic     valid;     // rob entry taken
        logic     new_reg;   // rd nonzero, free list pops
        areg_t    rd;
        preg_t    new_pr;
        rob_idx_t rob_idx;
    } alloc_t;

    typedef struct packed {
        logic  rs1_use;
        areg_t rs1;
        logic  rs2_use;
        areg_t rs2;
    } lookup_t;

    // registered dispatch result
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        areg_t    rd;
        preg_t    new_pr;
        preg_t    old_pr;     // freed at retire
        preg_t    src1_pr;
        logic     src1_ready;
        preg_t    src2_pr;
        logic     src2_ready;
    } rename_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        preg_t    pr;
    } cdb_t;

    typedef struct packed {
        logic  valid;
        areg_t rd;
        preg_t new_pr;
        preg_t old_pr;
    } retire_t;

endpackage

// ==== rename/dispatch_stage.sv ====
`timescale 1ns/1ps
// dispatch stage
// instruction register, register decode, stall and allocation request

module dispatch_stage (
    input  logic               clock,
    input  logic               reset,
    input  core_pkg::disp_in_t disp_in,
    output logic               stall,
    output core_pkg::lookup_t  lookup,
    input  core_pkg::preg_t    src1_pr,
    input  logic               src1_ready,
    input  core_pkg::preg_t    src2_pr,
    input  logic               src2_ready,
    input  core_pkg::preg_t    old_pr,
    input  core_pkg::preg_t    free_pr,
    input  logic               free_empty,
    input  core_pkg::rob_idx_t rob_tail,
    input  logic               rob_full,
    output core_pkg::alloc_t   alloc,
    output core_pkg::rename_t  rename_out
);

    core_pkg::disp_in_t ir;         // instruction register
    isa_pkg::opcode_t   op;
    logic               has_rd;
    logic               has_rs2;
    core_pkg::areg_t    rd;
    core_pkg::areg_t    rs1;
    core_pkg::areg_t    rs2;
    logic               needs_reg;  // rd nonzero
    logic               go;         // ir allocates on this edge

    //////////////////////////////////////////////////
    // instruction register
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            ir.valid <= 1'b0;
        end else if (!stall) begin  // held while stalled
            ir.valid <= disp_in.valid;
            ir.inst  <= disp_in.valid ? disp_in.inst
                                      : isa_pkg::inst_u'(isa_pkg::nop_word);  // bubble
        end
    end

    // decode, both views of the same word
    always_comb begin
        op      = ir.inst.r.opcode;
        has_rd  = (op != isa_pkg::op_store);
        has_rs2 = (op == isa_pkg::op_reg) || (op == isa_pkg::op_store);
        rd      = has_rd ? ir.inst.r.rd : '0;    // store bits here are immediate
        rs1     = ir.inst.i.rs1;
        rs2     = has_rs2 ? ir.inst.r.rs2 : '0;  // imm/load: no second source
    end

    assign needs_reg = (rd != '0);  // x0 never renamed

    // registered state only
    assign stall = ir.valid && (rob_full || (free_empty && needs_reg));
    assign go    = ir.valid && !stall;

    // x0 sources read tag zero, always ready
    assign lookup = '{rs1_use: (rs1 != '0), rs1: rs1,
                      rs2_use: (rs2 != '0), rs2: rs2};

    assign alloc = '{valid:   go,
                     new_reg: go && needs_reg,
                     rd:      rd,
                     new_pr:  needs_reg ? free_pr : '0,
                     rob_idx: rob_tail};

    //////////////////////////////////////////////////
    // rename result
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            rename_out.valid <= 1'b0;
        end else begin
            rename_out.valid <= go;
            if (go) begin
                rename_out.rob_idx    <= rob_tail;
                rename_out.rd         <= rd;
                rename_out.new_pr     <= alloc.new_pr;
                rename_out.old_pr     <= old_pr;  // freed when this retires
                rename_out.src1_pr    <= src1_pr;
                rename_out.src1_ready <= src1_ready;
                rename_out.src2_pr    <= src2_pr;
                rename_out.src2_ready <= src2_ready;
            end
        end
    end

endmodule

// ==== rename/map_table.sv ====
`timescale 1ns/1ps
// speculative map table
// architectural to physical tags plus one ready bit per physical register

module map_table (
    input  logic              clock,
    input  logic              reset,
    input  core_pkg::lookup_t lookup,
    input  core_pkg::alloc_t  alloc,
    input  core_pkg::cdb_t    cdb,
    output core_pkg::preg_t   src1_pr,
    output logic              src1_ready,
    output core_pkg::preg_t   src2_pr,
    output logic              src2_ready,
    output core_pkg::preg_t   old_pr
);

    core_pkg::preg_t               map [core_pkg::num_areg];
    logic [core_pkg::num_preg-1:0] ready;
    logic                          cdb_mapped;  // completed tag still named by some reg

    // source lookup, completion in flight counts as ready
    always_comb begin
        src1_pr    = lookup.rs1_use ? map[lookup.rs1] : '0;
        src2_pr    = lookup.rs2_use ? map[lookup.rs2] : '0;
        src1_ready = !lookup.rs1_use || ready[src1_pr]
                     || (cdb.valid && (cdb.pr == src1_pr));
        src2_ready = !lookup.rs2_use || ready[src2_pr]
                     || (cdb.valid && (cdb.pr == src2_pr));
    end

    assign old_pr = map[alloc.rd];  // x0 gives tag 0

    always_comb begin
        cdb_mapped = 1'b0;
        for (int i = 0; i < core_pkg::num_areg; i++) begin
            if (map[i] == cdb.pr) begin
                cdb_mapped = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // update
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::num_areg; i++) begin
                map[i] <= core_pkg::preg_t'(i);  // identity map
            end
            ready <= '1;
        end else begin
            if (cdb.valid && cdb_mapped) begin
                ready[cdb.pr] <= 1'b1;
            end
            // dispatch write comes last and wins
            if (alloc.new_reg) begin
                map[alloc.rd]       <= alloc.new_pr;
                ready[alloc.new_pr] <= 1'b0;
            end
        end
    end

endmodule

// ==== rename/free_list.sv ====
`timescale 1ns/1ps
// free list of physical registers
// circular queue, popped at dispatch and pushed at retire

module free_list (
    input  logic            clock,
    input  logic            reset,
    input  logic            pop,
    input  logic            push,
    input  core_pkg::preg_t push_pr,
    output core_pkg::preg_t free_pr,
    output logic            free_empty
);

    core_pkg::preg_t         slots [core_pkg::fl_depth];
    logic [core_pkg::fl_w-1:0] head;   // next tag handed out
    logic [core_pkg::fl_w-1:0] tail;   // next slot written at retire
    logic [core_pkg::fl_w:0]   count;  // 0..32

    assign free_pr    = slots[head];
    assign free_empty = (count == '0);  // registered, push shows next cycle

    //////////////////////////////////////////////////
    // queue state
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= (core_pkg::fl_w+1)'(core_pkg::fl_depth);  // full
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // slot contents, tags 32..63 after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::fl_depth; i++) begin
                slots[i] <= core_pkg::preg_t'(core_pkg::num_areg + i);
            end
        end else if (push) begin
            slots[tail] <= push_pr;
        end
    end

endmodule

// ==== rob/rob.sv ====
`timescale 1ns/1ps
// reorder buffer
// allocates at dispatch, marks completions, retires in order and frees old tags

module rob (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::alloc_t    alloc,
    input  core_pkg::preg_t     old_pr,
    input  core_pkg::cdb_t      cdb,
    output core_pkg::rob_idx_t  rob_tail,
    output logic                rob_full,
    output logic                free_push,
    output core_pkg::preg_t     free_push_pr,
    output core_pkg::retire_t   retire_out
);

    typedef struct packed {
        logic            done;
        core_pkg::areg_t rd;
        core_pkg::preg_t new_pr;
        core_pkg::preg_t old_pr;
    } entry_t;

    entry_t                     entries [core_pkg::rob_depth];
    core_pkg::rob_idx_t         head;
    core_pkg::rob_idx_t         tail;
    logic [core_pkg::rob_w:0]   count;      // 0..16
    logic                       retire_go;  // head done, pops this edge

    assign rob_tail  = tail;
    assign rob_full  = (count == (core_pkg::rob_w+1)'(core_pkg::rob_depth));
    assign retire_go = (count != '0) && entries[head].done;

    // freed tag goes straight to the free list, x0 frees nothing
    assign free_push    = retire_go && (entries[head].rd != '0);
    assign free_push_pr = entries[head].old_pr;

    //////////////////////////////////////////////////
    // pointers
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc.valid) begin
                tail <= tail + 1'b1;
            end
            if (retire_go) begin
                head <= head + 1'b1;
            end
            case ({alloc.valid, retire_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry storage, completion only hits allocated entries
    always_ff @(posedge clock) begin
        if (alloc.valid) begin
            entries[alloc.rob_idx] <= '{done: 1'b0, rd: alloc.rd,
                                        new_pr: alloc.new_pr, old_pr: old_pr};
        end
        if (cdb.valid) begin
            entries[cdb.rob_idx].done <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // retire record
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            retire_out.valid <= 1'b0;
        end else begin
            retire_out.valid <= retire_go;  // one per cycle
            if (retire_go) begin
                retire_out.rd     <= entries[head].rd;
                retire_out.new_pr <= entries[head].new_pr;
                retire_out.old_pr <= entries[head].old_pr;
            end
        end
    end

endmodule

// ==== src/rename_core.sv ====
`timescale 1ns/1ps
// rename core top level
// dispatch, map table, free list and reorder buffer wired together

module rename_core (
    input  logic               clock,
    input  logic               reset,
    input  core_pkg::disp_in_t disp_in,
    output logic               stall,
    input  core_pkg::cdb_t     cdb,
    output core_pkg::rename_t  rename_out,
    output core_pkg::retire_t  retire_out
);

    core_pkg::lookup_t  lookup;
    core_pkg::alloc_t   alloc;
    core_pkg::preg_t    src1_pr, src2_pr;
    logic               src1_ready, src2_ready;
    core_pkg::preg_t    old_pr;       // current mapping of rd
    core_pkg::preg_t    free_pr;      // free list head
    logic               free_empty;
    core_pkg::rob_idx_t rob_tail;
    logic               rob_full;
    logic               free_push;    // retire frees a tag
    core_pkg::preg_t    free_push_pr;

    dispatch_stage u_dispatch (
        .clock      (clock),
        .reset      (reset),
        .disp_in    (disp_in),
        .stall      (stall),
        .lookup     (lookup),
        .src1_pr    (src1_pr),
        .src1_ready (src1_ready),
        .src2_pr    (src2_pr),
        .src2_ready (src2_ready),
        .old_pr     (old_pr),
        .free_pr    (free_pr),
        .free_empty (free_empty),
        .rob_tail   (rob_tail),
        .rob_full   (rob_full),
        .alloc      (alloc),
        .rename_out (rename_out)
    );

    map_table u_map (
        .clock      (clock),
        .reset      (reset),
        .lookup     (lookup),
        .alloc      (alloc),
        .cdb        (cdb),
        .src1_pr    (src1_pr),
        .src1_ready (src1_ready),
        .src2_pr    (src2_pr),
        .src2_ready (src2_ready),
        .old_pr     (old_pr)
    );

    free_list u_free (
        .clock      (clock),
        .reset      (reset),
        .pop        (alloc.new_reg),   // only real destinations take a tag
        .push       (free_push),
        .push_pr    (free_push_pr),
        .free_pr    (free_pr),
        .free_empty (free_empty)
    );

    rob u_rob (
        .clock        (clock),
        .reset        (reset),
        .alloc        (alloc),
        .old_pr       (old_pr),
        .cdb          (cdb),
        .rob_tail     (rob_tail),
        .rob_full     (rob_full),
        .free_push    (free_push),
        .free_push_pr (free_push_pr),
        .retire_out   (retire_out)
    );

endmodule

// ==== test/rename_core_tb.sv ====
`timescale 1ns/1ps
// testbench for the rename core
// file driven dispatch and completion, checks every rename and retire beat

module rename_core_tb;

    logic               clock;
    logic               reset;
    core_pkg::disp_in_t disp_in;
    logic               stall;
    core_pkg::cdb_t     cdb;
    core_pkg::rename_t  rename_out;
    core_pkg::retire_t  retire_out;

    core_pkg::rename_t  exp_rename [$];  // expected rename beats, dispatch order
    core_pkg::retire_t  exp_retire [$];  // expected retire beats
    int                 live_rob [$];    // rob index of each unretired dispatch
    int                 live_pr [$];     // and its new tag, for completions
    bit                 live_done [$];   // completion sent for that dispatch
    int                 renamed_live;    // renamed but not yet retired
    int                 renamed_total;
    int                 accepted;        // taken into the instruction register
    int                 free_tags;       // tags left in the free list
    int                 next_rob;        // tail as the rob should see it
    int                 fd;

    rename_core u_dut (
        .clock      (clock),
        .reset      (reset),
        .disp_in    (disp_in),
        .stall      (stall),
        .cdb        (cdb),
        .rename_out (rename_out),
        .retire_out (retire_out)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;  // 10 ns

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input int got, input int exp);
        assert (got == exp) else begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s got %0d, expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    // build one word, queue its expected rename, hold it until taken
    task automatic dispatch_inst(input string op_name, input int rd, input int rs1,
                                 input int rs2, input int new_pr, input int old_pr,
                                 input int s1_pr, input int s1_rdy,
                                 input int s2_pr, input int s2_rdy);
        isa_pkg::inst_u     word;
        isa_pkg::opcode_t   op;
        core_pkg::disp_in_t d;
        core_pkg::rename_t  e;
        int                 waited;
        case (op_name)
            "reg":   op = isa_pkg::op_reg;
            "imm":   op = isa_pkg::op_imm;
            "load":  op = isa_pkg::op_load;
            "store": op = isa_pkg::op_store;
            default: stop_with_failure($sformatf("unknown opcode %s in stimulus", op_name));
        endcase
        if (op == isa_pkg::op_reg || op == isa_pkg::op_store) begin
            word.r = '{funct7: 7'd0, rs2: core_pkg::areg_t'(rs2), rs1: core_pkg::areg_t'(rs1),
                       funct3: 3'd0, rd: core_pkg::areg_t'(rd), opcode: op};
        end else begin
            // rs2 column lands in the immediate, must be ignored
            word.i = '{imm12: 12'(rs2), rs1: core_pkg::areg_t'(rs1), funct3: 3'd0,
                       rd: core_pkg::areg_t'(rd), opcode: op};
        end
        e.valid      = 1'b1;
        e.rob_idx    = core_pkg::rob_idx_t'(next_rob);
        e.rd         = (op == isa_pkg::op_store) ? '0 : core_pkg::areg_t'(rd);  // store bits are imm
        e.new_pr     = core_pkg::preg_t'(new_pr);
        e.old_pr     = core_pkg::preg_t'(old_pr);
        e.src1_pr    = core_pkg::preg_t'(s1_pr);
        e.src1_ready = s1_rdy[0];
        e.src2_pr    = core_pkg::preg_t'(s2_pr);
        e.src2_ready = s2_rdy[0];
        exp_rename.push_back(e);
        live_rob.push_back(next_rob);
        live_pr.push_back(new_pr);
        live_done.push_back(1'b0);
        next_rob = (next_rob + 1) % core_pkg::rob_depth;
        d.valid = 1'b1;
        d.inst  = word;
        @(posedge clock);
        disp_in <= d;
        waited = 0;
        do begin
            @(negedge clock);  // stall settled here
            waited++;
            if (waited > 200) begin
                stop_with_failure("timed out waiting for stall to drop before a dispatch");
            end
        end while (stall);
        @(posedge clock);  // taken on this edge
        accepted++;
        disp_in <= '0;
    endtask

    // broadcast the oldest in-flight instruction holding this rob index
    task automatic complete_entry(input int idx);
        core_pkg::cdb_t c;
        int             pos;
        @(posedge clock);
        pos = -1;
        for (int i = live_rob.size() - 1; i >= 0; i--) begin
            if (live_rob[i] == idx) begin
                pos = i;
            end
        end
        if (pos < 0) begin
            stop_with_failure($sformatf("completion of rob entry %0d, which is not in flight", idx));
        end
        live_done[pos] = 1'b1;
        c.valid   = 1'b1;
        c.rob_idx = core_pkg::rob_idx_t'(idx);
        c.pr      = core_pkg::preg_t'(live_pr[pos]);
        cdb <= c;
        @(posedge clock);
        cdb <= '0;  // one cycle only
    endtask

    //////////////////////////////////////////////////
    // output monitor
    //////////////////////////////////////////////////
    always @(negedge clock) begin : monitor
        core_pkg::rename_t e;
        core_pkg::retire_t r;
        logic              exp_stall;
        if (!reset && retire_out.valid) begin
            assert (exp_retire.size() > 0) else begin
                stop_with_failure("a retire record arrived when none was expected");
            end
            // oldest entry must have seen its completion
            assert (live_done.size() > 0 && live_done[0]) else begin
                stop_with_failure("a retire record arrived before its entry was completed");
            end
            r = exp_retire.pop_front();
            check_field("retire rd", retire_out.rd, r.rd);
            check_field("retire new_pr", retire_out.new_pr, r.new_pr);
            check_field("retire old_pr", retire_out.old_pr, r.old_pr);
            void'(live_rob.pop_front());  // retire order is dispatch order
            void'(live_pr.pop_front());
            void'(live_done.pop_front());
            renamed_live--;
            if (r.rd != '0) begin
                free_tags++;  // old tag back in the free list
            end
        end
        if (!reset && rename_out.valid) begin
            assert (exp_rename.size() > 0) else begin
                stop_with_failure("a rename result arrived when none was expected");
            end
            // at most rob_depth renamed and unretired
            assert (renamed_live < core_pkg::rob_depth) else begin
                stop_with_failure("a rename result appeared while the reorder buffer was full");
            end
            e = exp_rename.pop_front();
            check_field("rename rob_idx", rename_out.rob_idx, e.rob_idx);
            check_field("rename rd", rename_out.rd, e.rd);
            check_field("rename new_pr", rename_out.new_pr, e.new_pr);
            check_field("rename old_pr", rename_out.old_pr, e.old_pr);
            check_field("rename src1_pr", rename_out.src1_pr, e.src1_pr);
            check_field("rename src1_ready", rename_out.src1_ready, e.src1_ready);
            check_field("rename src2_pr", rename_out.src2_pr, e.src2_pr);
            check_field("rename src2_ready", rename_out.src2_ready, e.src2_ready);
            renamed_live++;
            renamed_total++;
            if (e.rd != '0) begin
                free_tags--;
            end
        end
        // held instruction stalls on a full rob or on no free tag for its rd
        if (!reset) begin
            exp_stall = (accepted > renamed_total)
                        && (renamed_live == core_pkg::rob_depth
                            || (free_tags == 0 && exp_rename[0].rd != '0));
            check_field("stall", stall, exp_stall);
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        string             line;
        string             cmd;
        string             op_name;
        int                n, rd, rs1, rs2, new_pr, old_pr;
        int                s1_pr, s1_rdy, s2_pr, s2_rdy, idx, waited;
        core_pkg::retire_t r;
        disp_in       = '0;
        cdb           = '0;
        reset         = 1'b1;
        renamed_live  = 0;
        renamed_total = 0;
        accepted      = 0;
        free_tags     = core_pkg::num_preg - core_pkg::num_areg;
        next_rob      = 0;
        fd = $fopen("test/rename_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open test/rename_stimulus.txt");
        end
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;  // blank or comment
            end
            n = $sscanf(line, "%s", cmd);
            case (cmd)
                "D": begin
                    n = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d", cmd, op_name,
                                rd, rs1, rs2, new_pr, old_pr, s1_pr, s1_rdy, s2_pr, s2_rdy);
                    if (n != 11) begin
                        stop_with_failure({"malformed dispatch line: ", line});
                    end
                    dispatch_inst(op_name, rd, rs1, rs2, new_pr, old_pr,
                                  s1_pr, s1_rdy, s2_pr, s2_rdy);
                end
                "C": begin
                    n = $sscanf(line, "%s %d", cmd, idx);
                    complete_entry(idx);
                end
                "W": begin
                    n = $sscanf(line, "%s %d", cmd, idx);
                    repeat (idx) @(posedge clock);
                end
                "R": begin
                    n = $sscanf(line, "%s %d %d %d", cmd, rd, new_pr, old_pr);
                    r.valid  = 1'b1;
                    r.rd     = core_pkg::areg_t'(rd);
                    r.new_pr = core_pkg::preg_t'(new_pr);
                    r.old_pr = core_pkg::preg_t'(old_pr);
                    exp_retire.push_back(r);
                end
                default: stop_with_failure({"unknown command in stimulus file: ", line});
            endcase
        end
        $fclose(fd);
        // drain outstanding beats
        waited = 0;
        while ((exp_rename.size() != 0 || exp_retire.size() != 0) && waited < 500) begin
            @(posedge clock);
            waited++;
        end
        if (exp_rename.size() == 0 && exp_retire.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_with_failure("timed out waiting for the expected rename and retire records");
        end
    end

endmodule

// ==== test/rename_stimulus.txt ====
# D op rd rs1 rs2 new_pr old_pr src1_pr src1_ready src2_pr src2_ready | C rob_idx | W cycles
# R rd new_pr old_pr   (expected retire, queued in dispatch order)
D reg 1 2 3 32 1 2 1 3 1
D imm 4 5 9 33 4 5 1 0 1
D reg 6 1 4 34 6 32 0 33 0
D reg 0 7 0 0 0 7 1 0 1
D load 7 6 5 35 7 34 0 0 1
D store 9 2 7 0 0 2 1 35 0
R 1 32 1
R 4 33 4
R 6 34 6
R 0 0 0
R 7 35 7
R 0 0 0
C 2
C 0
W 3
C 4
C 1
C 3
C 5
D reg 8 6 7 36 8 34 1 35 1
R 8 36 8
C 6
# sixteen uncompleted, then a seventeenth that must stall
D imm 9 0 3 37 9 0 1 0 1
D imm 10 0 3 38 10 0 1 0 1
D imm 11 0 3 39 11 0 1 0 1
D imm 12 0 3 40 12 0 1 0 1
D imm 13 0 3 41 13 0 1 0 1
D imm 14 0 3 42 14 0 1 0 1
D imm 15 0 3 43 15 0 1 0 1
D imm 16 0 3 44 16 0 1 0 1
D imm 17 0 3 45 17 0 1 0 1
D imm 18 0 3 46 18 0 1 0 1
D imm 19 0 3 47 19 0 1 0 1
D imm 20 0 3 48 20 0 1 0 1
D imm 21 0 3 49 21 0 1 0 1
D imm 22 0 3 50 22 0 1 0 1
D imm 23 0 3 51 23 0 1 0 1
D imm 24 0 3 52 24 0 1 0 1
D imm 25 9 3 53 25 37 1 0 1
W 10
R 9 37 9
C 7
R 10 38 10
R 11 39 11
R 12 40 12
R 13 41 13
R 14 42 14
R 15 43 15
R 16 44 16
R 17 45 17
R 18 46 18
R 19 47 19
R 20 48 20
R 21 49 21
C 8
C 9
C 10
C 11
C 12
C 13
C 14
C 15
C 0
C 1
C 2
C 3
# tags 54..63 run out, then retired tags come back in order
D imm 26 0 0 54 26 0 1 0 1
D imm 27 0 0 55 27 0 1 0 1
D imm 28 0 0 56 28 0 1 0 1
D imm 29 0 0 57 29 0 1 0 1
D imm 30 0 0 58 30 0 1 0 1
D imm 31 0 0 59 31 0 1 0 1
D imm 2 0 0 60 2 0 1 0 1
D imm 3 0 0 61 3 0 1 0 1
D imm 5 0 0 62 5 0 1 0 1
D imm 1 0 0 63 32 0 1 0 1
D imm 4 0 0 1 33 0 1 0 1
D imm 6 0 0 4 34 0 1 0 1

// ==== flist.f ====
common/isa_pkg.sv
common/core_pkg.sv
rename/dispatch_stage.sv
rename/map_table.sv
rename/free_list.sv
rob/rob.sv
src/rename_core.sv
test/rename_core_tb.sv
